// ==== source/rv_isa_pkg.sv ====
package rv_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [1:0]  size_t;

    //////////////////////////////
    // Instruction fields.
    //////////////////////////////

    localparam int RD_LSB = 7;
    localparam int F3_LSB = 12;

    // Major opcodes.
    localparam opcode_t OPC_LOAD  = 7'b0000011;
    localparam opcode_t OPC_STORE = 7'b0100011;

    //////////////////////////////
    // Access size and sign.
    //////////////////////////////

    localparam funct3_t F3_B  = 3'b000;
    localparam funct3_t F3_H  = 3'b001;
    localparam funct3_t F3_W  = 3'b010;
    localparam funct3_t F3_BU = 3'b100; // Zero-extended byte.
    localparam funct3_t F3_HU = 3'b101;

    // Low two funct3 bits.
    localparam size_t SZ_B = 2'b00;
    localparam size_t SZ_H = 2'b01;
    localparam size_t SZ_W = 2'b10;

endpackage

// ==== source/dbus_pkg.sv ====
package dbus_pkg;

    localparam int BUS_BYTES = 4;
    localparam int WORD_LSB  = 2; // Byte offset bits below the word index.

    typedef logic [31:0]          addr_t;
    typedef logic [BUS_BYTES-1:0] strobe_t;

    // Lane masks before the offset shift.
    localparam strobe_t STRB_B = 4'b0001;
    localparam strobe_t STRB_H = 4'b0011;
    localparam strobe_t STRB_W = 4'b1111;

    //////////////////////////////
    // RAM geometry and latency.
    //////////////////////////////

    localparam int RAM_WORDS     = 256;
    localparam int RAM_ADDR_BITS = 8;
    localparam int RAM_BASE_LAT  = 1;
    localparam int LAT_SEL_BITS  = 2; // Word index bits added to the base.
    localparam int LAT_CNT_BITS  = 3;

    typedef logic [RAM_ADDR_BITS-1:0] ram_idx_t;
    typedef logic [LAT_CNT_BITS-1:0]  lat_cnt_t;

endpackage

// ==== source/mem_stage_intake.sv ====
`timescale 1ns/10ps

module mem_stage_intake (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              ex_req,
    input  rv_isa_pkg::inst_t ex_inst,
    input  rv_isa_pkg::word_t ex_alu_result,
    input  rv_isa_pkg::word_t ex_store_data,
    output logic              ex_ack,
    output logic              it_valid,
    output rv_isa_pkg::inst_t it_inst,
    output dbus_pkg::addr_t   it_addr,
    output rv_isa_pkg::word_t it_store_data,
    input  logic              it_ready
);

    typedef enum logic [1:0] {idle, acked, drain} state_t;

    state_t state;
    logic   capture;
    logic   consume;

    assign capture = (state == idle) && ex_req; // Holding register is empty in idle.
    assign consume = it_valid && it_ready;
    assign ex_ack  = (state == acked);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= idle;
            it_valid <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (ex_req) begin
                        state <= acked;
                    end
                end
                acked: begin
                    // Item may still be waiting when the source lets go.
                    if (!ex_req) begin
                        state <= (it_valid && !consume) ? drain : idle;
                    end
                end
                drain: begin
                    if (consume) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase

            if (capture) begin
                it_valid <= 1'b1;
            end else if (consume) begin
                it_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            it_inst       <= ex_inst;
            it_addr       <= ex_alu_result; // ALU result is the address.
            it_store_data <= ex_store_data;
        end
    end

    ack_follows_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(ex_ack) |-> $past(ex_req))
        else $error("Intake acknowledged without a request.");

endmodule

// ==== source/load_store_unit.sv ====
`timescale 1ns/10ps

module load_store_unit (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 it_valid,
    input  rv_isa_pkg::inst_t    it_inst,
    input  dbus_pkg::addr_t      it_addr,
    input  rv_isa_pkg::word_t    it_store_data,
    output logic                 it_ready,
    output logic                 dreq,
    output logic                 dwrite,
    output dbus_pkg::addr_t      daddr,
    output rv_isa_pkg::word_t    dwdata,
    output dbus_pkg::strobe_t    dstrb,
    input  logic                 dack,
    input  rv_isa_pkg::word_t    drdata,
    output logic                 res_valid,
    output rv_isa_pkg::word_t    res_value,
    output rv_isa_pkg::reg_idx_t res_rd,
    output logic                 res_reg_write,
    output rv_isa_pkg::inst_t    res_inst,
    input  logic                 res_ready
);
    import rv_isa_pkg::*;
    import dbus_pkg::*;

    typedef enum logic [1:0] {idle, bus_req, bus_release, result} state_t;

    state_t  state;
    inst_t   held_inst;
    addr_t   held_addr;
    word_t   held_sdata;
    word_t   ld_word;
    funct3_t funct3;
    size_t   size;
    logic    is_load;
    logic    is_store;
    logic    it_mem;
    logic    take;
    strobe_t strb_base;
    word_t   lane_word;
    word_t   load_value;

    assign take     = it_valid && it_ready;
    assign it_mem   = (it_inst[6:0] == OPC_LOAD) || (it_inst[6:0] == OPC_STORE);
    assign is_load  = (held_inst[6:0] == OPC_LOAD);
    assign is_store = (held_inst[6:0] == OPC_STORE);
    assign funct3   = held_inst[F3_LSB +: $bits(funct3_t)];
    assign size     = funct3[1:0];

    //////////////////////////////
    // Control.
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (take) begin
                        state <= it_mem ? bus_req : result;
                    end
                end
                bus_req: begin
                    if (dack) begin
                        state <= bus_release;
                    end
                end
                bus_release: begin
                    if (!dack) begin
                        state <= result;
                    end
                end
                result: begin
                    if (res_ready) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            held_inst  <= it_inst;
            held_addr  <= it_addr;
            held_sdata <= it_store_data;
        end
        if (state == bus_req && dack) begin
            ld_word <= drdata; // Only valid while dack is high.
        end
    end

    //////////////////////////////
    // Lane alignment.
    //////////////////////////////

    always_comb begin
        case (size)
            SZ_B:    strb_base = STRB_B;
            SZ_H:    strb_base = STRB_H;
            default: strb_base = STRB_W;
        endcase
    end

    assign lane_word = ld_word >> {held_addr[1:0], 3'b000};

    always_comb begin
        case (funct3)
            F3_B:    load_value = {{24{lane_word[7]}}, lane_word[7:0]};
            F3_BU:   load_value = {24'b0, lane_word[7:0]};
            F3_H:    load_value = {{16{lane_word[15]}}, lane_word[15:0]};
            F3_HU:   load_value = {16'b0, lane_word[15:0]};
            F3_W:    load_value = ld_word;
            default: load_value = '0;
        endcase
    end

    assign it_ready      = (state == idle);
    assign dreq          = (state == bus_req);
    assign dwrite        = is_store;
    assign daddr         = held_addr;
    assign dwdata        = held_sdata << {held_addr[1:0], 3'b000};
    assign dstrb         = strb_base << held_addr[1:0];
    assign res_valid     = (state == result);
    assign res_value     = is_load ? load_value : held_addr;
    assign res_rd        = held_inst[RD_LSB +: $bits(reg_idx_t)];
    assign res_reg_write = !is_store; // Stores write no register.
    assign res_inst      = held_inst;

    half_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        dreq && (size == SZ_H) |-> (daddr[0] == 1'b0))
        else $error("Misaligned halfword access.");

    word_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        dreq && (size == SZ_W) |-> (daddr[1:0] == 2'b00))
        else $error("Misaligned word access.");

    dreq_held: assert property (@(posedge clk) disable iff (!arst_n)
        dreq && !dack |=> dreq && $stable(daddr) && $stable(dwrite))
        else $error("Data bus request changed before its acknowledge.");

endmodule

// ==== source/data_ram.sv ====
`timescale 1ns/10ps

module data_ram (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              dreq,
    input  logic              dwrite,
    input  dbus_pkg::addr_t   daddr,
    input  rv_isa_pkg::word_t dwdata,
    input  dbus_pkg::strobe_t dstrb,
    output logic              dack,
    output rv_isa_pkg::word_t drdata
);
    import rv_isa_pkg::*;
    import dbus_pkg::*;

    word_t    mem [RAM_WORDS] = '{default: '0};
    ram_idx_t idx;
    lat_cnt_t lat_now;
    lat_cnt_t remain;
    lat_cnt_t wait_cnt;
    logic     pending;
    logic     fire;

    assign idx     = daddr[WORD_LSB +: RAM_ADDR_BITS];
    assign lat_now = lat_cnt_t'(RAM_BASE_LAT) + lat_cnt_t'(idx[LAT_SEL_BITS-1:0]);

    // Counter only counts once the request has been seen.
    assign remain = pending ? wait_cnt : lat_now;
    assign fire   = dreq && !dack && (remain == lat_cnt_t'(1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dack     <= 1'b0;
            pending  <= 1'b0;
            wait_cnt <= '0;
        end else begin
            if (fire) begin
                dack    <= 1'b1;
                pending <= 1'b0;
            end else if (dreq && !dack) begin
                pending  <= 1'b1;
                wait_cnt <= remain - lat_cnt_t'(1);
            end else if (dack && !dreq) begin
                dack <= 1'b0; // Release phase.
            end
        end
    end

    //////////////////////////////
    // Storage.
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (fire) begin
            drdata <= mem[idx];
            if (dwrite) begin
                for (int b = 0; b < BUS_BYTES; b++) begin
                    if (dstrb[b]) begin
                        mem[idx][8*b +: 8] <= dwdata[8*b +: 8];
                    end
                end
            end
        end
    end

    ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(dack) |-> dreq)
        else $error("RAM acknowledged without a request.");

endmodule

// ==== source/writeback_port.sv ====
`timescale 1ns/10ps

module writeback_port (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 res_valid,
    input  rv_isa_pkg::word_t    res_value,
    input  rv_isa_pkg::reg_idx_t res_rd,
    input  logic                 res_reg_write,
    input  rv_isa_pkg::inst_t    res_inst,
    output logic                 res_ready,
    output logic                 wb_req,
    output rv_isa_pkg::word_t    wb_value,
    output rv_isa_pkg::reg_idx_t wb_rd,
    output logic                 wb_reg_write,
    output rv_isa_pkg::inst_t    wb_inst,
    input  logic                 wb_ack
);

    typedef enum logic [1:0] {empty, req, wait_release} state_t;

    state_t state;
    logic   take;

    assign res_ready = (state == empty);
    assign take      = res_valid && res_ready;
    assign wb_req    = (state == req);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= empty;
        end else begin
            case (state)
                empty: begin
                    if (res_valid) begin
                        state <= req;
                    end
                end
                req: begin
                    if (wb_ack) begin
                        state <= wait_release;
                    end
                end
                wait_release: begin
                    if (!wb_ack) begin
                        state <= empty; // Free for the next result.
                    end
                end
                default: state <= empty;
            endcase
        end
    end

    // Held output is also the forwarding source.
    always_ff @(posedge clk) begin
        if (take) begin
            wb_value     <= res_value;
            wb_rd        <= res_rd;
            wb_reg_write <= res_reg_write;
            wb_inst      <= res_inst;
        end
    end

    wb_stable: assert property (@(posedge clk) disable iff (!arst_n)
        wb_req && $past(wb_req) |-> $stable(wb_value) && $stable(wb_rd)
            && $stable(wb_reg_write) && $stable(wb_inst))
        else $error("Writeback data changed while the request was up.");

endmodule

// ==== source/memory_stage.sv ====
`timescale 1ns/10ps

module memory_stage (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 ex_req,
    input  rv_isa_pkg::inst_t    ex_inst,
    input  rv_isa_pkg::word_t    ex_alu_result,
    input  rv_isa_pkg::word_t    ex_store_data,
    output logic                 ex_ack,
    output logic                 wb_req,
    output rv_isa_pkg::word_t    wb_value,
    output rv_isa_pkg::reg_idx_t wb_rd,
    output logic                 wb_reg_write,
    output rv_isa_pkg::inst_t    wb_inst,
    input  logic                 wb_ack
);
    import rv_isa_pkg::*;
    import dbus_pkg::*;

    //////////////////////////////
    // Internal links.
    //////////////////////////////

    logic     it_valid;
    logic     it_ready;
    inst_t    it_inst;
    addr_t    it_addr;
    word_t    it_store_data;

    logic     dreq;
    logic     dwrite;
    logic     dack;
    addr_t    daddr;
    word_t    dwdata;
    word_t    drdata;
    strobe_t  dstrb;

    logic     res_valid;
    logic     res_ready;
    word_t    res_value;
    reg_idx_t res_rd;
    logic     res_reg_write;
    inst_t    res_inst;

    mem_stage_intake intake0 (
        .clk, .arst_n,
        .ex_req, .ex_inst, .ex_alu_result, .ex_store_data, .ex_ack,
        .it_valid, .it_inst, .it_addr, .it_store_data, .it_ready
    );

    load_store_unit lsu0 (
        .clk, .arst_n,
        .it_valid, .it_inst, .it_addr, .it_store_data, .it_ready,
        .dreq, .dwrite, .daddr, .dwdata, .dstrb, .dack, .drdata,
        .res_valid, .res_value, .res_rd, .res_reg_write, .res_inst, .res_ready
    );

    data_ram ram0 (
        .clk, .arst_n,
        .dreq, .dwrite, .daddr, .dwdata, .dstrb, .dack, .drdata
    );

    writeback_port wb_port0 (
        .clk, .arst_n,
        .res_valid, .res_value, .res_rd, .res_reg_write, .res_inst, .res_ready,
        .wb_req, .wb_value, .wb_rd, .wb_reg_write, .wb_inst, .wb_ack
    );

endmodule

// ==== tests/memory_stage_tb.sv ====
`timescale 1ns/10ps

module memory_stage_tb;
    import rv_isa_pkg::*;
    import dbus_pkg::*;

    localparam time         CLK_PERIOD  = 100ns;
    localparam time         DRIVE_DELAY = 5ns;
    localparam logic [31:0] SEED        = 32'hc757b97e;
    localparam opcode_t     OPC_OP_IMM  = 7'b0010011;
    localparam int          N_RANDOM    = 24;
    localparam int          N_ITEMS     = 25 + N_RANDOM; // 4 ALU, 2 word, 19 byte/half.
    localparam int          MAX_CYCLES  = 40 * N_ITEMS + 100;

    logic     clk;
    logic     arst_n;
    logic     ex_req;
    inst_t    ex_inst;
    word_t    ex_alu_result;
    word_t    ex_store_data;
    logic     ex_ack;
    logic     wb_req;
    word_t    wb_value;
    reg_idx_t wb_rd;
    logic     wb_reg_write;
    inst_t    wb_inst;
    logic     wb_ack;

    word_t    ref_mem [RAM_WORDS];
    string    exp_name [$];
    word_t    exp_value [$];
    reg_idx_t exp_rd [$];
    logic     exp_rw [$];
    inst_t    exp_inst [$];
    int       sent;

    memory_stage dut0 (
        .clk, .arst_n,
        .ex_req, .ex_inst, .ex_alu_result, .ex_store_data, .ex_ack,
        .wb_req, .wb_value, .wb_rd, .wb_reg_write, .wb_inst, .wb_ack
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic value_error(string name, string field, logic [31:0] exp, logic [31:0] act);
        fail_run($sformatf("FAIL %s %s: expected %h, actual %h", name, field, exp, act));
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // Reference load with lane select and extension.
    function automatic word_t load_ref(funct3_t f3, word_t w, logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[8*off +: 8];
        h = w[16*off[1] +: 16];
        case (f3)
            F3_B:    return {{24{b[7]}}, b};
            F3_BU:   return {24'b0, b};
            F3_H:    return {{16{h[15]}}, h};
            F3_HU:   return {16'b0, h};
            default: return w;
        endcase
    endfunction

    // Queues the expected result, then runs one four-phase cycle.
    task automatic send_item(string name, opcode_t opc, funct3_t f3, word_t alu, word_t sdata);
        logic [31:0] rnd;
        reg_idx_t    rd;
        inst_t       inst;
        logic [7:0]  idx;
        logic [1:0]  off;
        word_t       value;
        rnd   = $urandom;
        rd    = rnd[21:17];
        inst  = {rnd[16:0], f3, rd, opc};
        idx   = alu[9:2];
        off   = alu[1:0];
        value = alu; // Everything but a load passes the ALU result.
        if (opc == OPC_LOAD) begin
            value = load_ref(f3, ref_mem[idx], off);
        end else if (opc == OPC_STORE) begin
            case (f3)
                F3_B:    ref_mem[idx][8*off +: 8] = sdata[7:0];
                F3_H:    ref_mem[idx][16*off[1] +: 16] = sdata[15:0];
                default: ref_mem[idx] = sdata;
            endcase
        end
        exp_name.push_back(name);
        exp_value.push_back(value);
        exp_rd.push_back(inst[11:7]);
        exp_rw.push_back(opc != OPC_STORE);
        exp_inst.push_back(inst);

        ex_inst       = inst;
        ex_alu_result = alu;
        ex_store_data = sdata;
        ex_req        = 1'b1;
        do next_cycle(); while (!ex_ack);
        ex_req = 1'b0;
        do next_cycle(); while (ex_ack);
        sent++;
    endtask

    task automatic check_result();
        string    name;
        word_t    ev;
        reg_idx_t erd;
        logic     erw;
        inst_t    einst;
        if (exp_value.size() == 0) begin
            fail_run("Writeback raised a request with no item outstanding.");
        end else begin
            name  = exp_name.pop_front();
            ev    = exp_value.pop_front();
            erd   = exp_rd.pop_front();
            erw   = exp_rw.pop_front();
            einst = exp_inst.pop_front();
            inst_ok: assert (wb_inst == einst) else value_error(name, "wb_inst", einst, wb_inst);
            value_ok: assert (wb_value == ev) else value_error(name, "wb_value", ev, wb_value);
            rd_ok: assert (wb_rd == erd) else value_error(name, "wb_rd", erd, wb_rd);
            rw_ok: assert (wb_reg_write == erw)
                else value_error(name, "wb_reg_write", erw, wb_reg_write);
        end
    endtask

    //////////////////////////////
    // Protocol checks.
    //////////////////////////////

    ex_ack_after_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(ex_ack) |-> $past(ex_req))
        else fail_run("Execute acknowledge rose without a request.");

    ex_req_after_ack: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(ex_req) |-> ex_ack)
        else fail_run("Execute request fell before its acknowledge.");

    ex_req_rise: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(ex_req) |-> !ex_ack)
        else fail_run("Execute request rose while the old acknowledge was up.");

    ex_stable: assert property (@(posedge clk) disable iff (!arst_n)
        ex_req && $past(ex_req) |-> $stable(ex_inst) && $stable(ex_alu_result)
            && $stable(ex_store_data))
        else fail_run("Execute data changed while the request was up.");

    wb_ack_after_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(wb_ack) |-> wb_req)
        else fail_run("Writeback acknowledge rose without a request.");

    wb_req_after_ack: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(wb_req) |-> $past(wb_ack))
        else fail_run("Writeback request fell before its acknowledge.");

    wb_stable: assert property (@(posedge clk) disable iff (!arst_n)
        wb_req && $past(wb_req) |-> $stable(wb_value) && $stable(wb_rd)
            && $stable(wb_reg_write) && $stable(wb_inst))
        else fail_run("Writeback data changed while the request was up.");

    //////////////////////////////
    // Writeback sink and watchdog.
    //////////////////////////////

    initial begin : wb_sink
        int unsigned delay;
        forever begin
            next_cycle();
            if (wb_req) begin
                check_result();
                delay = $urandom_range(5, 0);
                repeat (delay) next_cycle();
                wb_ack = 1'b1;
                do next_cycle(); while (wb_req);
                wb_ack = 1'b0;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > MAX_CYCLES) begin
                fail_run($sformatf("Timeout after %0d cycles, %0d items sent.", cycles, sent));
            end
        end
    end

    initial begin : stimulus
        logic [31:0] rnd;
        word_t       data;
        funct3_t     f3;
        logic [1:0]  off;
        logic [1:0]  kind;
        void'($urandom(SEED));
        clk           = 1'b0;
        arst_n        = 1'b0;
        ex_req        = 1'b0;
        ex_inst       = '0;
        ex_alu_result = '0;
        ex_store_data = '0;
        wb_ack        = 1'b0;
        sent          = 0;
        foreach (ref_mem[i]) ref_mem[i] = '0;
        repeat (4) @(posedge clk);
        #DRIVE_DELAY arst_n = 1'b1;
        next_cycle();
        reset_idle: assert (!ex_ack && !wb_req)
            else fail_run("Handshake outputs were not idle after reset.");

        for (int i = 0; i < 4; i++) send_item("alu_pass", OPC_OP_IMM, F3_B, $urandom, $urandom);

        send_item("store_word", OPC_STORE, F3_W, 32'h40, $urandom);
        send_item("load_word", OPC_LOAD, F3_W, 32'h40, '0);

        // Offsets 1 and 3 carry a set sign bit.
        for (int o = 0; o < 4; o++) begin
            data    = $urandom;
            data[7] = o[0];
            send_item("store_byte", OPC_STORE, F3_B, word_t'(32'h80 + o), data);
        end
        for (int o = 0; o < 4; o++) begin
            send_item("load_byte", OPC_LOAD, F3_B, word_t'(32'h80 + o), '0);
        end
        for (int o = 0; o < 4; o++) begin
            send_item("load_byte_u", OPC_LOAD, F3_BU, word_t'(32'h80 + o), '0);
        end
        for (int o = 0; o < 4; o += 2) begin
            data     = $urandom;
            data[15] = o[1];
            send_item("store_half", OPC_STORE, F3_H, word_t'(32'h80 + o), data);
        end
        for (int o = 0; o < 4; o += 2) begin
            send_item("load_half", OPC_LOAD, F3_H, word_t'(32'h80 + o), '0);
            send_item("load_half_u", OPC_LOAD, F3_HU, word_t'(32'h80 + o), '0);
        end
        send_item("load_word_lanes", OPC_LOAD, F3_W, 32'h80, '0);

        // Word index low bits walk 0..3 for every RAM latency.
        for (int i = 0; i < N_RANDOM; i++) begin
            rnd  = $urandom;
            data = $urandom;
            kind = rnd[9:8];
            case (rnd[12:11])
                2'd0: begin
                    f3  = (rnd[15] && kind != 2'd2) ? F3_BU : F3_B;
                    off = rnd[14:13];
                end
                2'd1: begin
                    f3  = (rnd[15] && kind != 2'd2) ? F3_HU : F3_H;
                    off = {rnd[13], 1'b0};
                end
                default: begin
                    f3  = F3_W;
                    off = 2'b00;
                end
            endcase
            case (kind)
                2'd0:    send_item("random_alu", OPC_OP_IMM, f3, data, $urandom);
                2'd2:    send_item("random_store", OPC_STORE, f3,
                             {22'b0, rnd[5:0], i[1:0], off}, data);
                default: send_item("random_load", OPC_LOAD, f3,
                             {22'b0, rnd[5:0], i[1:0], off}, '0);
            endcase
        end

        // Last handshake runs out, then idle cycles where a repeat would show.
        while (exp_value.size() != 0 || wb_req || wb_ack) next_cycle();
        repeat (8) next_cycle();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== verilog.f ====
source/rv_isa_pkg.sv
source/dbus_pkg.sv
source/mem_stage_intake.sv
source/load_store_unit.sv
source/data_ram.sv
source/writeback_port.sv
source/memory_stage.sv
tests/memory_stage_tb.sv
